// ==== design/dma_defines.svh ====
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// ===========================================================================
// copy engine sizing
// ===========================================================================

// byte address width on both AXI channel sets
`define DMA_ADDR_W      10

// data beat width
`define DMA_DATA_W      32

// byte offset bits inside one data word
`define DMA_ADDRLSB     2

`define DMA_LGMAXBURST  4   // 16 beats per burst
`define DMA_LGFIFO      5   // 32 word beat store

`endif

// ==== design/dma_pkg.sv ====
`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

	// byte address, same width for source and destination
	typedef logic [`DMA_ADDR_W-1:0] addr_t;

	// one data beat
	typedef logic [`DMA_DATA_W-1:0] word_t;

	// word count, one bit over the address space in words
	typedef logic [`DMA_ADDR_W-`DMA_ADDRLSB:0] wcount_t;

	typedef logic [`DMA_LGMAXBURST:0] blen_t;   // 1..16 beats

	// AXI response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

endpackage

`default_nettype wire

// ==== design/copy_control.sv ====
`default_nettype none

`include "dma_defines.svh"

module copy_control
	import dma_pkg::*;
(
	input  wire logic      ACLK,
	input  wire logic      ARESETn,
	input  wire logic      start,
	input  wire addr_t     src_addr,
	input  wire addr_t     dst_addr,
	input  wire addr_t     len_bytes,
	input  wire logic      writes_complete,
	input  wire logic      rvalid,
	input  wire logic      rready,
	input  wire logic      bvalid,
	input  wire logic      bready,
	input  wire axi_resp_e rresp,
	input  wire axi_resp_e bresp,
	output logic           busy,
	output logic           done,
	output logic           resp_error,
	output addr_t          src_base,
	output addr_t          dst_base,
	output wcount_t        total_words
);

	addr_t   src_live;     // word aligned inputs
	addr_t   dst_live;
	wcount_t words_live;
	addr_t   src_q;
	addr_t   dst_q;
	wcount_t words_q;
	logic    accept;
	logic    bad_resp;

	assign accept     = start && !busy;
	assign src_live   = {src_addr[`DMA_ADDR_W-1:`DMA_ADDRLSB], {`DMA_ADDRLSB{1'b0}}};
	assign dst_live   = {dst_addr[`DMA_ADDR_W-1:`DMA_ADDRLSB], {`DMA_ADDRLSB{1'b0}}};
	assign words_live = wcount_t'(len_bytes[`DMA_ADDR_W-1:`DMA_ADDRLSB]);

	// issuers load while idle, so they see the live descriptor on the start edge
	assign src_base    = busy ? src_q   : src_live;
	assign dst_base    = busy ? dst_q   : dst_live;
	assign total_words = busy ? words_q : words_live;

	always_ff @(posedge ACLK) begin
		if (accept) begin
			src_q   <= src_live;
			dst_q   <= dst_live;
			words_q <= words_live;
		end
	end

	// busy until the last write response, done pulses as busy falls
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
			end else if (busy && writes_complete) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	assign bad_resp = (rvalid && rready && (rresp != OKAY))
		|| (bvalid && bready && (bresp != OKAY));

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			resp_error <= 1'b0;
		else if (accept)
			resp_error <= 1'b0;   // new copy, fresh flag
		else if (bad_resp)
			resp_error <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/read_burst_issuer.sv ====
`default_nettype none

`include "dma_defines.svh"

module read_burst_issuer
	import dma_pkg::*;
(
	input  wire logic    ACLK,
	input  wire logic    ARESETn,
	input  wire logic    busy,
	input  wire addr_t   src_base,
	input  wire wcount_t total_words,
	input  wire wcount_t free_credit,
	input  wire logic    arready,
	input  wire logic    rvalid,
	input  wire logic    rlast,
	input  wire word_t   rdata,
	output addr_t        araddr,
	output logic [7:0]   arlen,
	output logic         arvalid,
	output logic         rready,
	output logic         reserve,
	output blen_t        reserve_len,
	output logic         push,
	output word_t        push_data
);

	localparam wcount_t MAXBURST = wcount_t'(1 << `DMA_LGMAXBURST);

	addr_t   rd_addr;      // address of the next burst
	wcount_t words_left;   // words not yet requested
	wcount_t bursts_out;   // AR accepted, RLAST not yet seen
	blen_t   next_len;
	blen_t   ar_blen;      // beats of the AR on the bus
	blen_t   arlen_m1;
	logic    issue;
	logic    r_beat;
	logic    r_done;

	// ======================================================================
	// address channel
	// ======================================================================

	assign next_len = (words_left >= MAXBURST) ? blen_t'(MAXBURST) : blen_t'(words_left);

	// a whole max burst of space must be free before asking
	assign issue = busy && !arvalid && (words_left != '0) && (free_credit >= MAXBURST);

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			arvalid    <= 1'b0;
			rd_addr    <= '0;
			words_left <= '0;
		end else if (!busy) begin
			arvalid    <= 1'b0;
			rd_addr    <= src_base;
			words_left <= total_words;
		end else if (issue) begin
			arvalid    <= 1'b1;
			rd_addr    <= rd_addr + (addr_t'(next_len) << `DMA_ADDRLSB);
			words_left <= words_left - wcount_t'(next_len);
		end else if (arready) begin
			arvalid    <= 1'b0;
		end
	end

	always_ff @(posedge ACLK) begin
		if (issue) begin
			araddr  <= rd_addr;
			ar_blen <= next_len;
		end
	end

	assign arlen_m1    = ar_blen - 1'b1;
	assign arlen       = 8'(arlen_m1);
	assign reserve     = arvalid && arready;   // credit taken as the AR goes out
	assign reserve_len = ar_blen;

	// ======================================================================
	// data channel
	// ======================================================================

	assign r_beat = rvalid && rready;
	assign r_done = r_beat && rlast;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			bursts_out <= '0;
		end else if (!busy) begin
			bursts_out <= '0;
		end else begin
			case ({reserve, r_done})
				2'b10:   bursts_out <= bursts_out + 1'b1;
				2'b01:   bursts_out <= bursts_out - 1'b1;
				default: ;
			endcase
		end
	end

	// space is already reserved, so every beat of a live burst is taken
	assign rready    = (bursts_out != '0);
	assign push      = r_beat;
	assign push_data = rdata;

endmodule

`default_nettype wire

// ==== design/beat_fifo.sv ====
`default_nettype none

`include "dma_defines.svh"

module beat_fifo
	import dma_pkg::*;
#(
	parameter int LGDEPTH = `DMA_LGFIFO
) (
	input  wire logic    ACLK,
	input  wire logic    ARESETn,
	input  wire logic    busy,
	input  wire logic    push,
	input  wire word_t   push_data,
	input  wire logic    pop,
	input  wire logic    reserve,
	input  wire blen_t   reserve_len,
	input  wire logic    claim,
	input  wire blen_t   claim_len,
	output word_t        head_data,
	output wcount_t      free_credit,
	output wcount_t      ready_words
);

	localparam int DEPTH = 1 << LGDEPTH;

	word_t              mem [DEPTH];
	logic [LGDEPTH-1:0] wr_ptr;
	logic [LGDEPTH-1:0] rd_ptr;
	wcount_t            take_len;    // credit taken this cycle
	wcount_t            claim_amt;   // data claimed this cycle

	// ======================================================================
	// storage
	// ======================================================================

	always_ff @(posedge ACLK) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (!busy) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign head_data = mem[rd_ptr];

	// ======================================================================
	// credit counters
	// ======================================================================

	assign take_len  = reserve ? wcount_t'(reserve_len) : wcount_t'(0);
	assign claim_amt = claim ? wcount_t'(claim_len) : wcount_t'(0);

	// space not yet promised to a read burst
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			free_credit <= wcount_t'(DEPTH);
		else if (!busy)
			free_credit <= wcount_t'(DEPTH);
		else
			free_credit <= free_credit + wcount_t'(pop) - take_len;
	end

	// stored words no write burst has claimed
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			ready_words <= '0;
		else if (!busy)
			ready_words <= '0;
		else
			ready_words <= ready_words + wcount_t'(push) - claim_amt;
	end

endmodule

`default_nettype wire

// ==== design/write_burst_issuer.sv ====
`default_nettype none

`include "dma_defines.svh"

module write_burst_issuer
	import dma_pkg::*;
(
	input  wire logic    ACLK,
	input  wire logic    ARESETn,
	input  wire logic    busy,
	input  wire addr_t   dst_base,
	input  wire wcount_t total_words,
	input  wire wcount_t ready_words,
	input  wire word_t   head_data,
	input  wire logic    awready,
	input  wire logic    wready,
	input  wire logic    bvalid,
	output addr_t        awaddr,
	output logic [7:0]   awlen,
	output logic         awvalid,
	output word_t        wdata,
	output logic         wvalid,
	output logic         wlast,
	output logic         bready,
	output logic         claim,
	output blen_t        claim_len,
	output logic         pop,
	output logic         writes_complete
);

	localparam wcount_t MAXBURST = wcount_t'(1 << `DMA_LGMAXBURST);

	addr_t   wr_addr;      // address of the next burst
	wcount_t words_left;   // words not yet put in an AW
	wcount_t bursts_out;   // AW accepted, B not yet seen
	blen_t   next_len;
	blen_t   aw_blen;
	blen_t   awlen_m1;
	blen_t   beats_left;   // beats of the current burst, this one included
	logic    issue;
	logic    w_beat;
	logic    w_done;
	logic    b_beat;

	assign next_len = (words_left >= MAXBURST) ? blen_t'(MAXBURST) : blen_t'(words_left);

	assign w_beat = wvalid && wready;
	assign w_done = w_beat && wlast;
	assign b_beat = bvalid && bready;

	// whole burst must already sit in the FIFO, W bus free or freeing now
	assign issue = busy && !awvalid && (words_left != '0)
		&& (ready_words >= wcount_t'(next_len)) && (!wvalid || w_done);

	// ======================================================================
	// address channel
	// ======================================================================

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			awvalid    <= 1'b0;
			wr_addr    <= '0;
			words_left <= '0;
		end else if (!busy) begin
			awvalid    <= 1'b0;
			wr_addr    <= dst_base;
			words_left <= total_words;
		end else if (issue) begin
			awvalid    <= 1'b1;
			wr_addr    <= wr_addr + (addr_t'(next_len) << `DMA_ADDRLSB);
			words_left <= words_left - wcount_t'(next_len);
		end else if (awready) begin
			awvalid    <= 1'b0;
		end
	end

	always_ff @(posedge ACLK) begin
		if (issue) begin
			awaddr  <= wr_addr;
			aw_blen <= next_len;
		end
	end

	assign awlen_m1  = aw_blen - 1'b1;
	assign awlen     = 8'(awlen_m1);
	assign claim     = awvalid && awready;
	assign claim_len = aw_blen;

	// ======================================================================
	// data channel
	// ======================================================================

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			wvalid     <= 1'b0;
			wlast      <= 1'b0;
			beats_left <= '0;
		end else if (!busy) begin
			wvalid     <= 1'b0;
			wlast      <= 1'b0;
			beats_left <= '0;
		end else if (issue) begin
			wvalid     <= 1'b1;   // first beat goes up with AWVALID
			wlast      <= (next_len == blen_t'(1));
			beats_left <= next_len;
		end else if (w_done) begin
			wvalid     <= 1'b0;
			wlast      <= 1'b0;
			beats_left <= '0;
		end else if (w_beat) begin
			wlast      <= (beats_left == blen_t'(2));
			beats_left <= beats_left - 1'b1;
		end
	end

	// FIFO head only moves on an accepted beat
	assign wdata = head_data;
	assign pop   = w_beat;

	// ======================================================================
	// response channel
	// ======================================================================

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			bursts_out <= '0;
		end else if (!busy) begin
			bursts_out <= '0;
		end else begin
			case ({claim, b_beat})
				2'b10:   bursts_out <= bursts_out + 1'b1;
				2'b01:   bursts_out <= bursts_out - 1'b1;
				default: ;
			endcase
		end
	end

	assign bready = busy;

	// nothing left to send and every burst answered
	assign writes_complete = (words_left == '0) && (bursts_out == '0) && !awvalid && !wvalid;

endmodule

`default_nettype wire

// ==== design/axi_copy_dma.sv ====
`default_nettype none

module axi_copy_dma
	import dma_pkg::*;
(
	input  wire logic      ACLK,
	input  wire logic      ARESETn,

	// descriptor and status
	input  wire logic      start,
	input  wire addr_t     src_addr,
	input  wire addr_t     dst_addr,
	input  wire addr_t     len_bytes,
	output logic           busy,
	output logic           done,
	output logic           resp_error,

	// read address channel
	output addr_t          m_axi_araddr,
	output logic [7:0]     m_axi_arlen,
	output logic           m_axi_arvalid,
	input  wire logic      m_axi_arready,

	// read data channel
	input  wire word_t     m_axi_rdata,
	input  wire axi_resp_e m_axi_rresp,
	input  wire logic      m_axi_rlast,
	input  wire logic      m_axi_rvalid,
	output logic           m_axi_rready,

	// write address channel
	output addr_t          m_axi_awaddr,
	output logic [7:0]     m_axi_awlen,
	output logic           m_axi_awvalid,
	input  wire logic      m_axi_awready,

	// write data channel
	output word_t          m_axi_wdata,
	output logic           m_axi_wlast,
	output logic           m_axi_wvalid,
	input  wire logic      m_axi_wready,

	// write response channel
	input  wire axi_resp_e m_axi_bresp,
	input  wire logic      m_axi_bvalid,
	output logic           m_axi_bready
);

	addr_t   src_base;
	addr_t   dst_base;
	wcount_t total_words;
	logic    writes_complete;

	// read side to beat store
	logic    reserve;
	blen_t   reserve_len;
	logic    push;
	word_t   push_data;

	// write side to beat store
	logic    claim;
	blen_t   claim_len;
	logic    pop;

	wcount_t free_credit;
	wcount_t ready_words;
	word_t   head_data;

	copy_control copy_control_i (
		.ACLK            (ACLK),
		.ARESETn         (ARESETn),
		.start           (start),
		.src_addr        (src_addr),
		.dst_addr        (dst_addr),
		.len_bytes       (len_bytes),
		.writes_complete (writes_complete),
		.rvalid          (m_axi_rvalid),
		.rready          (m_axi_rready),
		.bvalid          (m_axi_bvalid),
		.bready          (m_axi_bready),
		.rresp           (m_axi_rresp),
		.bresp           (m_axi_bresp),
		.busy            (busy),
		.done            (done),
		.resp_error      (resp_error),
		.src_base        (src_base),
		.dst_base        (dst_base),
		.total_words     (total_words)
	);

	read_burst_issuer read_burst_issuer_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.busy        (busy),
		.src_base    (src_base),
		.total_words (total_words),
		.free_credit (free_credit),
		.arready     (m_axi_arready),
		.rvalid      (m_axi_rvalid),
		.rlast       (m_axi_rlast),
		.rdata       (m_axi_rdata),
		.araddr      (m_axi_araddr),
		.arlen       (m_axi_arlen),
		.arvalid     (m_axi_arvalid),
		.rready      (m_axi_rready),
		.reserve     (reserve),
		.reserve_len (reserve_len),
		.push        (push),
		.push_data   (push_data)
	);

	beat_fifo beat_fifo_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.busy        (busy),
		.push        (push),
		.push_data   (push_data),
		.pop         (pop),
		.reserve     (reserve),
		.reserve_len (reserve_len),
		.claim       (claim),
		.claim_len   (claim_len),
		.head_data   (head_data),
		.free_credit (free_credit),
		.ready_words (ready_words)
	);

	write_burst_issuer write_burst_issuer_i (
		.ACLK            (ACLK),
		.ARESETn         (ARESETn),
		.busy            (busy),
		.dst_base        (dst_base),
		.total_words     (total_words),
		.ready_words     (ready_words),
		.head_data       (head_data),
		.awready         (m_axi_awready),
		.wready          (m_axi_wready),
		.bvalid          (m_axi_bvalid),
		.awaddr          (m_axi_awaddr),
		.awlen           (m_axi_awlen),
		.awvalid         (m_axi_awvalid),
		.wdata           (m_axi_wdata),
		.wvalid          (m_axi_wvalid),
		.wlast           (m_axi_wlast),
		.bready          (m_axi_bready),
		.claim           (claim),
		.claim_len       (claim_len),
		.pop             (pop),
		.writes_complete (writes_complete)
	);

endmodule

`default_nettype wire

// ==== verification/axi_slave_mem.sv ====
`default_nettype none

`include "dma_defines.svh"

module axi_slave_mem
	import dma_pkg::*;
(
	input  wire logic                   ACLK,
	input  wire logic                   ARESETn,
	input  wire logic                   stall_en,
	input  wire logic [`DMA_ADDR_W-1:0] error_addr,   // read word answered with SLVERR
	input  wire logic [`DMA_ADDR_W-1:0] araddr,
	input  wire logic [7:0]             arlen,
	input  wire logic                   arvalid,
	output logic                        arready,
	output logic [`DMA_DATA_W-1:0]      rdata,
	output axi_resp_e                   rresp,
	output logic                        rlast,
	output logic                        rvalid,
	input  wire logic                   rready,
	input  wire logic [`DMA_ADDR_W-1:0] awaddr,
	input  wire logic [7:0]             awlen,
	input  wire logic                   awvalid,
	output logic                        awready,
	input  wire logic [`DMA_DATA_W-1:0] wdata,
	input  wire logic                   wlast,
	input  wire logic                   wvalid,
	output logic                        wready,
	output axi_resp_e                   bresp,
	output logic                        bvalid,
	input  wire logic                   bready
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [`DMA_DATA_W-1:0] mem [256];
	int         seed = 32'heae9_1dd6;
	logic       rd_active;
	logic [7:0] rd_word;
	logic [7:0] rd_left;   // beats after the current one
	logic       wr_active;
	logic [7:0] wr_word;

	function logic pick_ready();
		pick_ready = !stall_en || (($random(seed) & 3) != 0);
	endfunction

	// ======================================================================
	// read side, one burst at a time
	// ======================================================================

	assign rdata = mem[rd_word];
	assign rlast = rd_active && (rd_left == 8'd0);
	assign rresp = ({rd_word, 2'b00} == error_addr) ? SLVERR : OKAY;

	always @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			arready   <= 1'b0;
			rvalid    <= 1'b0;
			rd_active <= 1'b0;
			rd_word   <= '0;
			rd_left   <= '0;
		end else if (!rd_active) begin
			if (arvalid && arready) begin
				rd_active <= 1'b1;
				rd_word   <= araddr[`DMA_ADDR_W-1:`DMA_ADDRLSB];
				rd_left   <= arlen;
				arready   <= 1'b0;
				rvalid    <= pick_ready();
			end else begin
				arready <= pick_ready();
			end
		end else if (rvalid && rready) begin
			if (rd_left == 8'd0) begin
				rd_active <= 1'b0;
				rvalid    <= 1'b0;
				arready   <= pick_ready();
			end else begin
				rd_word <= rd_word + 8'd1;
				rd_left <= rd_left - 8'd1;
				rvalid  <= pick_ready();
			end
		end else if (!rvalid) begin
			rvalid <= pick_ready();   // once up, held until taken
		end
	end

	// ======================================================================
	// write side, W only taken after its AW
	// ======================================================================

	assign bresp = OKAY;

	always @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			wr_active <= 1'b0;
			wr_word   <= '0;
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (!wr_active) begin
				if (awvalid && awready) begin
					wr_active <= 1'b1;
					wr_word   <= awaddr[`DMA_ADDR_W-1:`DMA_ADDRLSB];
					awready   <= 1'b0;
					wready    <= pick_ready();
				end else begin
					awready <= !bvalid && pick_ready();
				end
			end else if (wvalid && wready) begin
				mem[wr_word] <= wdata;
				wr_word      <= wr_word + 8'd1;
				if (wlast) begin
					wr_active <= 1'b0;
					wready    <= 1'b0;
					bvalid    <= 1'b1;
				end else begin
					wready <= pick_ready();
				end
			end else begin
				wready <= pick_ready();
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/axi_copy_dma_asserts.sv ====
`default_nettype none

`include "dma_defines.svh"

module axi_copy_dma_asserts (
	input wire logic                        ACLK,
	input wire logic                        ARESETn,
	input wire logic                        start,
	input wire logic                        busy,
	input wire logic                        done,
	input wire logic [`DMA_ADDR_W-1:0]      src_addr,
	input wire logic [`DMA_ADDR_W-1:0]      dst_addr,
	input wire logic [`DMA_ADDR_W-1:0]      len_bytes,
	input wire logic [`DMA_ADDR_W-1:0]      araddr,
	input wire logic [7:0]                  arlen,
	input wire logic                        arvalid,
	input wire logic                        arready,
	input wire logic                        rvalid,
	input wire logic                        rready,
	input wire logic [`DMA_ADDR_W-1:0]      awaddr,
	input wire logic [7:0]                  awlen,
	input wire logic                        awvalid,
	input wire logic                        awready,
	input wire logic [`DMA_DATA_W-1:0]      wdata,
	input wire logic                        wlast,
	input wire logic                        wvalid,
	input wire logic                        wready,
	input wire logic                        bvalid,
	input wire logic                        bready
);

	timeunit 1ns;
	timeprecision 100ps;

	int          fail_count = 0;
	logic [7:0]  beat_cnt;
	logic [7:0]  cur_len;
	logic [7:0]  exp_len;
	logic [15:0] ar_end;
	logic [15:0] aw_end;
	logic [15:0] exp_src;
	logic [15:0] exp_dst;
	logic [15:0] exp_bytes;

	// beat position inside the W burst
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			beat_cnt <= '0;
			cur_len  <= '0;
		end else begin
			if (awvalid)
				cur_len <= awlen;
			if (wvalid && wready)
				beat_cnt <= wlast ? 8'd0 : beat_cnt + 8'd1;
		end
	end

	// word aligned descriptor of the copy in flight
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			exp_src   <= '0;
			exp_dst   <= '0;
			exp_bytes <= '0;
		end else if (start && !busy) begin
			exp_src   <= 16'(src_addr) & 16'hFFFC;
			exp_dst   <= 16'(dst_addr) & 16'hFFFC;
			exp_bytes <= 16'(len_bytes) & 16'hFFFC;
		end
	end

	assign exp_len = awvalid ? awlen : cur_len;   // first beat goes with the AW
	assign ar_end  = 16'(araddr) + ((16'(arlen) + 16'd1) << 2);
	assign aw_end  = 16'(awaddr) + ((16'(awlen) + 16'd1) << 2);

	// ======================================================================
	// burst shape
	// ======================================================================

	a_ar_shape: assert property (@(posedge ACLK) disable iff (!ARESETn)
		arvalid |-> arlen <= 8'd15 && 16'(araddr) >= exp_src
			&& ar_end <= exp_src + exp_bytes)
	else begin
		$error("AR burst out of range");
		fail_count++;
	end

	a_aw_shape: assert property (@(posedge ACLK) disable iff (!ARESETn)
		awvalid |-> awlen <= 8'd15 && 16'(awaddr) >= exp_dst
			&& aw_end <= exp_dst + exp_bytes)
	else begin
		$error("AW burst out of range");
		fail_count++;
	end

	a_wlast: assert property (@(posedge ACLK) disable iff (!ARESETn)
		wvalid && wready |-> wlast == (beat_cnt == exp_len))
	else begin
		$error("wlast on the wrong beat");
		fail_count++;
	end

	// ======================================================================
	// stable payload while stalled
	// ======================================================================

	a_ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
	else begin
		$error("AR dropped or changed while stalled");
		fail_count++;
	end

	a_aw_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
	else begin
		$error("AW dropped or changed while stalled");
		fail_count++;
	end

	a_w_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
	else begin
		$error("W dropped or changed while stalled");
		fail_count++;
	end

	// read space is reserved up front, so no R beat waits
	a_r_taken: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rvalid |-> rready)
	else begin
		$error("R beat refused");
		fail_count++;
	end

	a_b_taken: assert property (@(posedge ACLK) disable iff (!ARESETn)
		bvalid |-> bready)
	else begin
		$error("B response refused");
		fail_count++;
	end

	a_done: assert property (@(posedge ACLK) disable iff (!ARESETn)
		done |-> !busy && $past(busy))
	else begin
		$error("done not on the falling edge of busy");
		fail_count++;
	end

endmodule

bind axi_copy_dma axi_copy_dma_asserts asserts_i (
	.ACLK        (ACLK),
	.ARESETn     (ARESETn),
	.start       (start),
	.busy        (busy),
	.done        (done),
	.src_addr    (src_addr),
	.dst_addr    (dst_addr),
	.len_bytes   (len_bytes),
	.araddr      (m_axi_araddr),
	.arlen       (m_axi_arlen),
	.arvalid     (m_axi_arvalid),
	.arready     (m_axi_arready),
	.rvalid      (m_axi_rvalid),
	.rready      (m_axi_rready),
	.awaddr      (m_axi_awaddr),
	.awlen       (m_axi_awlen),
	.awvalid     (m_axi_awvalid),
	.awready     (m_axi_awready),
	.wdata       (m_axi_wdata),
	.wlast       (m_axi_wlast),
	.wvalid      (m_axi_wvalid),
	.wready      (m_axi_wready),
	.bvalid      (m_axi_bvalid),
	.bready      (m_axi_bready)
);

`default_nettype wire

// ==== verification/tb_axi_copy_dma.sv ====
`default_nettype none

`include "dma_defines.svh"

module tb_axi_copy_dma
	import dma_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	logic ACLK = 1'b0;
	logic ARESETn, start, stall_en;
	addr_t src_addr, dst_addr, len_bytes, error_addr;
	logic busy, done, resp_error;
	addr_t araddr, awaddr;
	logic [7:0] arlen, awlen;
	logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
	logic wlast, wvalid, wready, bvalid, bready;
	word_t rdata, wdata;
	axi_resp_e rresp, bresp;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int mark;
	logic traffic_seen;

	always #10 ACLK = ~ACLK;

	axi_copy_dma axi_copy_dma_i (
		.ACLK(ACLK), .ARESETn(ARESETn), .start(start), .src_addr(src_addr),
		.dst_addr(dst_addr), .len_bytes(len_bytes), .busy(busy), .done(done),
		.resp_error(resp_error),
		.m_axi_araddr(araddr), .m_axi_arlen(arlen), .m_axi_arvalid(arvalid),
		.m_axi_arready(arready), .m_axi_rdata(rdata), .m_axi_rresp(rresp),
		.m_axi_rlast(rlast), .m_axi_rvalid(rvalid), .m_axi_rready(rready),
		.m_axi_awaddr(awaddr), .m_axi_awlen(awlen), .m_axi_awvalid(awvalid),
		.m_axi_awready(awready), .m_axi_wdata(wdata), .m_axi_wlast(wlast),
		.m_axi_wvalid(wvalid), .m_axi_wready(wready), .m_axi_bresp(bresp),
		.m_axi_bvalid(bvalid), .m_axi_bready(bready)
	);

	axi_slave_mem mem_i (
		.ACLK(ACLK), .ARESETn(ARESETn), .stall_en(stall_en), .error_addr(error_addr),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	always @(posedge ACLK)
		if (arvalid || awvalid)
			traffic_seen <= 1'b1;

	function automatic word_t word_pattern(input int idx);
		return (32'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_0000 ^ 32'(idx);
	endfunction

	function automatic int error_total();
		return errors + axi_copy_dma_i.asserts_i.fail_count;
	endfunction

	task automatic launch_copy(input addr_t src, input addr_t dst, input addr_t len);
		@(posedge ACLK);
		#2;
		start     = 1'b1;
		src_addr  = src;
		dst_addr  = dst;
		len_bytes = len;
		@(posedge ACLK);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_done(input int max_cycles);
		int n;
		n = 0;
		while (!done && n < max_cycles) begin
			@(posedge ACLK);
			#1;
			n++;
		end
		if (!done) begin
			$display("timeout at %0t: done never came", $time);
			errors++;
		end
	endtask

	// words copied, then the word after must be untouched
	task automatic check_copy(input addr_t src, input addr_t dst, input int words);
		int s;
		int d;
		s = src >> 2;
		d = dst >> 2;
		for (int k = 0; k <= words; k++) begin
			if (mem_i.mem[d + k] !== word_pattern(k < words ? s + k : d + k)) begin
				$display("[FAIL] t=%0t dst word %0d: got %h expected %h", $time, d + k,
					mem_i.mem[d + k], word_pattern(k < words ? s + k : d + k));
				errors++;
			end
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (error_total() != mark)
			failed_tests++;
		$display("test %0d %s: %s", tests, name, (error_total() == mark) ? "ok" : "failed");
		mark = error_total();
	endtask

	initial begin
		ARESETn      = 1'b0;
		start        = 1'b0;
		stall_en     = 1'b0;
		src_addr     = '0;
		dst_addr     = '0;
		len_bytes    = '0;
		error_addr   = 10'h3FC;
		traffic_seen = 1'b0;
		mark         = 0;
		for (int i = 0; i < 256; i++)
			mem_i.mem[i] = word_pattern(i);
		repeat (10) @(posedge ACLK);
		#2;
		ARESETn = 1'b1;

		// outputs that come out of reset low
		expect_bit("busy", busy, 1'b0);
		expect_bit("done", done, 1'b0);
		expect_bit("resp_error", resp_error, 1'b0);
		expect_bit("m_axi_arvalid", arvalid, 1'b0);
		expect_bit("m_axi_awvalid", awvalid, 1'b0);
		expect_bit("m_axi_wvalid", wvalid, 1'b0);
		expect_bit("m_axi_wlast", wlast, 1'b0);
		expect_bit("m_axi_rready", rready, 1'b0);
		expect_bit("m_axi_bready", bready, 1'b0);
		report_test("reset state");

		// ==================================================================
		// copies
		// ==================================================================
		launch_copy(10'h000, 10'h1B0, 10'd20);
		wait_done(500);
		check_copy(10'h000, 10'h1B0, 5);
		launch_copy(10'h014, 10'h1D0, 10'd5);
		wait_done(500);
		check_copy(10'h014, 10'h1D0, 1);
		report_test("short copy");

		stall_en = 1'b1;
		launch_copy(10'h000, 10'h200, 10'd400);
		wait_done(5000);
		check_copy(10'h000, 10'h200, 100);
		report_test("long copy with stalls");

		error_addr = 10'h048;
		launch_copy(10'h040, 10'h3A0, 10'd32);
		wait_done(2000);
		check_copy(10'h040, 10'h3A0, 8);
		expect_bit("resp_error", resp_error, 1'b1);
		error_addr = 10'h3FC;
		launch_copy(10'h080, 10'h3C0, 10'd8);
		expect_bit("resp_error", resp_error, 1'b0);
		wait_done(2000);
		check_copy(10'h080, 10'h3C0, 2);
		expect_bit("resp_error", resp_error, 1'b0);
		report_test("error flag");

		// ==================================================================
		// zero length and start while busy
		// ==================================================================
		@(posedge ACLK);
		#2;
		traffic_seen = 1'b0;
		start = 1'b1;
		len_bytes = 10'd3;
		@(posedge ACLK);
		#2;
		start = 1'b0;
		expect_bit("busy", busy, 1'b1);
		expect_bit("done", done, 1'b0);
		@(posedge ACLK);
		#1;
		expect_bit("done", done, 1'b1);
		if (traffic_seen) begin
			$display("zero length copy: AXI address traffic seen");
			errors++;
		end
		launch_copy(10'h0C0, 10'h140, 10'd32);
		repeat (3) @(posedge ACLK);
		launch_copy(10'h000, 10'h1A0, 10'd16);   // ignored, engine busy
		wait_done(2000);
		check_copy(10'h0C0, 10'h140, 8);
		check_copy(10'h1A0, 10'h1A0, 0);
		report_test("zero length and busy start");

		repeat (5) @(posedge ACLK);
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, error_total());
		if (error_total() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/dma_pkg.sv
design/copy_control.sv
design/read_burst_issuer.sv
design/beat_fifo.sv
design/write_burst_issuer.sv
design/axi_copy_dma.sv
verification/axi_slave_mem.sv
verification/axi_copy_dma_asserts.sv
verification/tb_axi_copy_dma.sv
